// ==== files.f ====
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/instr_class_decode.sv
verilog/single_cycle_decode.sv
verilog/reg_list_sequencer.sv
verilog/thumb_controller.sv
tb/thumb_controller_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ns --top-module thumb_controller_tb \
    -f files.f -o thumb_controller_sim

sim_out="$(./obj_dir/thumb_controller_sim 2>&1)" || true
echo "$sim_out"

if grep -q "All checks passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== tb/controller_testdata.txt ====
# instruction  ctrl_o  reg_addr  offset_imm, all hex, one row per clock cycle
# ctrl_o from the top bit: valid flag mwr mrd rwr wb a_src[3] b_src[3] op[4] stall a2 dst r3
# shift immediate, register and 3-bit immediate add and subtract
0088 c8150 0 00000000
0888 c8160 0 00000000
1088 c8170 0 00000000
1888 c8000 0 00000000
1a88 c8010 0 00000000
1c88 c8100 0 00000000
1e88 c8110 0 00000000
# data processing, codes 0 to 15
400a c8020 0 00000000
404a c8040 0 00000000
408a c8050 0 00000000
40ca c8060 0 00000000
410a c8070 0 00000000
414a c8000 0 00000000
418a c8010 0 00000000
41ca c8080 0 00000000
420a c0020 0 00000000
424a c9010 0 00000000
428a c0010 0 00000000
42ca c0000 0 00000000
430a c8030 0 00000000
434a c8090 0 00000000
438a c80a0 0 00000000
43ca c80b0 0 00000000
# register offset stores and loads
5088 a0001 0 00000000
5488 a0001 0 00000000
5688 9c000 0 00000000
5888 9c000 0 00000000
# immediate offset word, byte, halfword and SP-relative
6088 a4100 0 00000000
7888 9c100 0 00000000
8088 a4100 0 00000000
8888 9c100 0 00000000
9001 a4100 0 00000000
9801 9c100 0 00000000
# opcodes outside the decoded groups
4400 00000 0 00000000
b400 00000 0 00000000
e000 00000 0 00000000
# branch with link pair, then a lone second half
f000 80000 0 00000000
f800 89910 0 00000002
0088 c8150 0 00000000
f800 80000 0 00000000
0088 c8150 0 00000000
# store multiple r0 r2 r5 r7, base r1
c1a5 a040c 0 00000000
c1a5 a040c 2 00000004
c1a5 a040c 5 00000008
c1a5 a040c 7 0000000c
c1a5 88402 1 00000010
# load multiple r1 r2, base r5
cd06 8c40a 2 00000004
cd06 8c40a 1 00000000
cd06 88402 5 00000008
# load multiple r1 r2, base r2 is in the list
ca06 8c40a 2 00000004
ca06 8c40a 1 00000000
ca06 80402 2 00000008
end

// ==== tb/thumb_controller_tb.sv ====
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module thumb_controller_tb import ctrl_pkg::*; ();

    // upper bound on data rows, a missing end marker stops the run here
    localparam int MAX_ROWS = 200;
    localparam string DATA_FILE = "tb/controller_testdata.txt";

    logic                     clk_i;
    logic                     reset_i;
    logic [`CTRL_INSTR_W-1:0] instruction_i;
    ctrl_word_t               ctrl_o;
    xfer_info_t               xfer_o;

    int row_num;

    thumb_controller dut_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instruction_i (instruction_i),
        .ctrl_o        (ctrl_o),
        .xfer_o        (xfer_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped at data row %0d", row_num);
    endtask

    task automatic check_ctrl(input string name, input ctrl_word_t expected,
                              input ctrl_word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %0t ns row %0d %s expected %h got %h",
                                $time, row_num, name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input logic [`CTRL_REG_ADDR_W-1:0] expected,
                              input logic [`CTRL_REG_ADDR_W-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %0t ns row %0d %s expected %h got %h",
                                $time, row_num, name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input logic [`CTRL_WORD_W-1:0] expected,
                              input logic [`CTRL_WORD_W-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %0t ns row %0d %s expected %h got %h",
                                $time, row_num, name, expected, actual));
        end
    endtask

    // one data row is one clock cycle of the controller
    task automatic apply_row(input logic [`CTRL_INSTR_W-1:0] instr,
                             input ctrl_word_t exp_ctrl,
                             input logic [`CTRL_REG_ADDR_W-1:0] exp_addr,
                             input logic [`CTRL_WORD_W-1:0] exp_offset);
        @(posedge clk_i);
        instruction_i <= instr;
        // the decode is combinational, so the outputs are settled at the falling edge
        @(negedge clk_i);
        check_ctrl("ctrl_o", exp_ctrl, ctrl_o);
        check_addr("xfer_o.reg_addr", exp_addr, xfer_o.reg_addr);
        check_word("xfer_o.offset_imm", exp_offset, xfer_o.offset_imm);
    endtask

    initial begin
        int                            fd;
        int                            status;
        int                            fields;
        bit                            done;
        string                         line;
        logic [`CTRL_INSTR_W-1:0]      instr;
        logic [$bits(ctrl_word_t)-1:0] ctrl_raw;
        logic [`CTRL_REG_ADDR_W-1:0]   exp_addr;
        logic [`CTRL_WORD_W-1:0]       exp_offset;

        reset_i <= 1'b1;
        instruction_i <= '0;
        row_num = 0;
        done = 1'b0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abort_run("the data file tb/controller_testdata.txt could not be opened");
        end

        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;

        while (!done) begin
            status = $fgets(line, fd);
            if (status == 0) begin
                abort_run("the data file ended before its end marker");
            end else if (line.len() >= 3 && line.substr(0, 2) == "end") begin
                done = 1'b1;
            end else if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h %h", instr, ctrl_raw, exp_addr, exp_offset);
                row_num++;
                if (fields != 4) begin
                    abort_run($sformatf("data row %0d does not hold four hex columns", row_num));
                end
                if (row_num > MAX_ROWS) begin
                    abort_run("the data file has too many rows and no end marker was found");
                end
                apply_row(instr, ctrl_word_t'(ctrl_raw), exp_addr, exp_offset);
            end
        end

        $fclose(fd);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== verilog/ctrl_cfg.svh ====
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// width of a data word and of an ALU operand
`define CTRL_WORD_W 32

// one instruction halfword
`define CTRL_INSTR_W 16

// register file address
`define CTRL_REG_ADDR_W 4

// multiple transfers only reach the low registers r0 to r7
`define CTRL_REG_LIST_W 8

// counts the beats of a multiple transfer, must hold CTRL_REG_LIST_W
`define CTRL_BEAT_W 4

// address step between two transferred registers
`define CTRL_WORD_BYTES 4

`endif

// ==== verilog/ctrl_pkg.sv ====
`include "ctrl_cfg.svh"

package ctrl_pkg;

    // instruction groups the controller knows about
    typedef enum logic [2:0] {
        SHIFT_ADD_SUB,
        DATA_PROC,
        LS_REG,
        LS_IMM,
        STORE_MULT,
        LOAD_MULT,
        BL_HALF,
        INVALID
    } instr_class_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, LSL, LSR, ASR, ROR, MUL, BIC, NOT
    } alu_op_e;

    // ACCUM feeds the ALU with the offset coming from the sequencer
    typedef enum logic [2:0] {
        REG, IMM, ZERO, PC, ACCUM
    } operand_src_e;

    typedef enum logic {ALU, MEMORY} wb_src_e;

    typedef enum logic {INSTRUCTION, CTRL_UNIT} addr_src_e;

    typedef struct packed {
        logic         is_valid;
        logic         update_flag;
        logic         mem_write;
        logic         mem_read;
        logic         reg_write;
        wb_src_e      wb_src;
        operand_src_e alu_a_src;
        operand_src_e alu_b_src;
        alu_op_e      alu_op;
        logic         stall;
        addr_src_e    addr2_src;
        addr_src_e    dest_src;
        logic         reg3_select;
    } ctrl_word_t;

    typedef struct packed {
        logic [`CTRL_REG_ADDR_W-1:0] reg_addr;
        logic [`CTRL_WORD_W-1:0]     offset_imm;
    } xfer_info_t;

    // a valid instruction that does nothing, every decode rule starts from here
    localparam ctrl_word_t CTRL_WORD_DEFAULT = '{
        is_valid: 1'b1, update_flag: 1'b0, mem_write: 1'b0, mem_read: 1'b0,
        reg_write: 1'b0, wb_src: ALU, alu_a_src: REG, alu_b_src: REG,
        alu_op: ADD, stall: 1'b0, addr2_src: INSTRUCTION,
        dest_src: INSTRUCTION, reg3_select: 1'b0
    };

endpackage

// ==== verilog/instr_class_decode.sv ====
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module instr_class_decode import ctrl_pkg::*; (
    input  logic [`CTRL_INSTR_W-1:0] instruction_i,
    output instr_class_e             class_o
);

    logic [5:0] opcode;

    // the group is fully given by the top six bits
    assign opcode = instruction_i[15:10];

    always_comb begin
        casez (opcode)
            6'b000???: class_o = SHIFT_ADD_SUB;
            6'b010000: class_o = DATA_PROC;
            6'b0101??: class_o = LS_REG;
            // word and byte immediate offsets
            6'b011???: class_o = LS_IMM;
            // halfword and SP-relative offsets decode the same way
            6'b100???: class_o = LS_IMM;
            6'b11000?: class_o = STORE_MULT;
            6'b11001?: class_o = LOAD_MULT;
            // both halves of the long branch with link
            6'b1111??: class_o = BL_HALF;
            default:   class_o = INVALID;
        endcase
    end

endmodule

// ==== verilog/reg_list_sequencer.sv ====
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module reg_list_sequencer import ctrl_pkg::*; (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic [`CTRL_INSTR_W-1:0] instruction_i,
    input  instr_class_e             class_i,
    input  ctrl_word_t               base_ctrl_i,
    input  logic [`CTRL_WORD_W-1:0]  link_imm_i,
    output ctrl_word_t               ctrl_o,
    output xfer_info_t               xfer_o
);

    localparam int WORD_W = `CTRL_WORD_W;
    localparam int ADDR_W = `CTRL_REG_ADDR_W;
    localparam int LIST_W = `CTRL_REG_LIST_W;
    localparam int BEAT_W = `CTRL_BEAT_W;
    localparam logic [WORD_W-1:0] STEP = WORD_W'(`CTRL_WORD_BYTES);

    // lowest set bit when ascending, highest set bit otherwise
    function automatic logic [ADDR_W-1:0] pick_reg(
        input logic [LIST_W-1:0] bits,
        input logic              descending
    );
        logic [ADDR_W-1:0] idx;
        logic              found;
        idx = '0;
        found = 1'b0;
        for (int i = 0; i < LIST_W; i++) begin
            if (bits[i] && (descending || !found)) begin
                idx = ADDR_W'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    function automatic logic [BEAT_W-1:0] count_set(input logic [LIST_W-1:0] bits);
        logic [BEAT_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < LIST_W; i++) begin
            sum = sum + BEAT_W'(bits[i]);
        end
        return sum;
    endfunction

    // registers of the list that are still waiting to be moved
    logic [LIST_W-1:0] hold_mask_q;
    logic [BEAT_W-1:0] beat_q;
    logic              base_in_list_q;

    logic              is_load;
    logic              is_multi;
    logic [LIST_W-1:0] pending;
    logic [ADDR_W-1:0] pick_addr;
    logic [ADDR_W-1:0] base_addr;
    logic [BEAT_W-1:0] list_cnt;
    logic              busy;

    assign is_load = (class_i == LOAD_MULT);
    assign is_multi = (class_i == STORE_MULT) || is_load;
    assign pending = instruction_i[LIST_W-1:0] & hold_mask_q;
    assign pick_addr = pick_reg(pending, is_load);
    assign base_addr = ADDR_W'(instruction_i[10:8]);
    assign list_cnt = count_set(instruction_i[LIST_W-1:0]);
    assign busy = is_multi && (pending != '0);

    always_comb begin
        ctrl_o = base_ctrl_i;
        xfer_o.reg_addr = '0;
        xfer_o.offset_imm = link_imm_i;

        if (is_multi) begin
            ctrl_o = CTRL_WORD_DEFAULT;
            // the ALU adds the offset to the base register in every cycle
            ctrl_o.alu_b_src = ACCUM;
            ctrl_o.dest_src = CTRL_UNIT;
            ctrl_o.stall = busy;
            if (busy) begin
                xfer_o.reg_addr = pick_addr;
                if (is_load) begin
                    // loads run downwards from the top of the block
                    ctrl_o.wb_src = MEMORY;
                    ctrl_o.reg_write = 1'b1;
                    xfer_o.offset_imm = (WORD_W'(list_cnt) - WORD_W'(beat_q) - 1) * STEP;
                end else begin
                    ctrl_o.addr2_src = CTRL_UNIT;
                    ctrl_o.dest_src = INSTRUCTION;
                    ctrl_o.mem_write = 1'b1;
                    xfer_o.offset_imm = WORD_W'(beat_q) * STEP;
                end
            end else begin
                // write-back of the base, the loaded value wins if the base was in the list
                xfer_o.reg_addr = base_addr;
                xfer_o.offset_imm = WORD_W'(list_cnt) * STEP;
                ctrl_o.reg_write = !(is_load && base_in_list_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || !busy) begin
            hold_mask_q <= '1;
            beat_q <= '0;
            base_in_list_q <= 1'b0;
        end else begin
            hold_mask_q[pick_addr[$clog2(LIST_W)-1:0]] <= 1'b0;
            beat_q <= beat_q + 1'b1;
            if (pick_addr == base_addr) begin
                base_in_list_q <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/single_cycle_decode.sv ====
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module single_cycle_decode import ctrl_pkg::*; (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic [`CTRL_INSTR_W-1:0] instruction_i,
    input  instr_class_e             class_i,
    output ctrl_word_t               ctrl_o,
    output logic [`CTRL_WORD_W-1:0]  link_imm_o
);

    // the PC seen on the second BL half is one halfword past the return point
    localparam logic [`CTRL_WORD_W-1:0] LINK_CORRECTION = `CTRL_WORD_W'(2);

    logic link_pending_q;
    logic link_set;

    always_comb begin
        ctrl_o = CTRL_WORD_DEFAULT;
        link_set = 1'b0;
        link_imm_o = '0;

        case (class_i)
            SHIFT_ADD_SUB: begin
                ctrl_o.update_flag = 1'b1;
                ctrl_o.reg_write = 1'b1;
                casez (instruction_i[13:9])
                    5'b000??: begin
                        ctrl_o.alu_op = LSL;
                        ctrl_o.alu_b_src = IMM;
                    end
                    5'b001??: begin
                        ctrl_o.alu_op = LSR;
                        ctrl_o.alu_b_src = IMM;
                    end
                    5'b010??: begin
                        ctrl_o.alu_op = ASR;
                        ctrl_o.alu_b_src = IMM;
                    end
                    5'b01101: ctrl_o.alu_op = SUB;
                    5'b01110, 5'b110??: ctrl_o.alu_b_src = IMM;
                    5'b01111, 5'b111??: begin
                        ctrl_o.alu_op = SUB;
                        ctrl_o.alu_b_src = IMM;
                    end
                    // move is computed as zero plus the immediate
                    5'b100??: begin
                        ctrl_o.alu_a_src = ZERO;
                        ctrl_o.alu_b_src = IMM;
                    end
                    5'b101??: begin
                        ctrl_o.alu_op = SUB;
                        ctrl_o.alu_b_src = IMM;
                        ctrl_o.reg_write = 1'b0;
                    end
                    // register add keeps the defaults
                    default: ;
                endcase
            end
            DATA_PROC: begin
                ctrl_o.update_flag = 1'b1;
                ctrl_o.reg_write = 1'b1;
                case (instruction_i[9:6])
                    4'd0:  ctrl_o.alu_op = AND;
                    4'd1:  ctrl_o.alu_op = XOR;
                    4'd2:  ctrl_o.alu_op = LSL;
                    4'd3:  ctrl_o.alu_op = LSR;
                    4'd4:  ctrl_o.alu_op = ASR;
                    4'd5:  ctrl_o.alu_op = ADD;
                    4'd6:  ctrl_o.alu_op = SUB;
                    4'd7:  ctrl_o.alu_op = ROR;
                    4'd8: begin
                        ctrl_o.alu_op = AND;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'd9: begin
                        ctrl_o.alu_op = SUB;
                        ctrl_o.alu_a_src = ZERO;
                    end
                    4'd10: begin
                        ctrl_o.alu_op = SUB;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'd11: begin
                        ctrl_o.alu_op = ADD;
                        ctrl_o.reg_write = 1'b0;
                    end
                    4'd12: ctrl_o.alu_op = OR;
                    4'd13: ctrl_o.alu_op = MUL;
                    4'd14: ctrl_o.alu_op = BIC;
                    default: ctrl_o.alu_op = NOT;
                endcase
            end
            LS_REG: begin
                if (instruction_i[11] || instruction_i[10:9] == 2'b11) begin
                    ctrl_o.wb_src = MEMORY;
                    ctrl_o.mem_read = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                end else begin
                    // stores need the third register port for the data
                    ctrl_o.mem_write = 1'b1;
                    ctrl_o.reg3_select = 1'b1;
                end
            end
            LS_IMM: begin
                ctrl_o.alu_b_src = IMM;
                ctrl_o.wb_src = MEMORY;
                if (instruction_i[11]) begin
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.mem_read = 1'b1;
                end else begin
                    ctrl_o.mem_write = 1'b1;
                end
            end
            BL_HALF: begin
                if (!link_pending_q) begin
                    link_set = 1'b1;
                end else begin
                    // return address is PC minus two
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.alu_op = SUB;
                    ctrl_o.alu_a_src = PC;
                    ctrl_o.alu_b_src = IMM;
                    link_imm_o = LINK_CORRECTION;
                end
            end
            INVALID: ctrl_o.is_valid = 1'b0;
            // multiple transfers are built by the sequencer
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            link_pending_q <= 1'b0;
        end else begin
            link_pending_q <= link_set;
        end
    end

endmodule

// ==== verilog/thumb_controller.sv ====
`timescale 1ns/1ns
`include "ctrl_cfg.svh"

module thumb_controller import ctrl_pkg::*; (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic [`CTRL_INSTR_W-1:0] instruction_i,
    output ctrl_word_t               ctrl_o,
    output xfer_info_t               xfer_o
);

    instr_class_e            instr_class;
    ctrl_word_t              base_ctrl;
    logic [`CTRL_WORD_W-1:0] link_imm;

    instr_class_decode class_dec_i (
        .instruction_i (instruction_i),
        .class_o       (instr_class)
    );

    single_cycle_decode single_dec_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instruction_i (instruction_i),
        .class_i       (instr_class),
        .ctrl_o        (base_ctrl),
        .link_imm_o    (link_imm)
    );

    // the sequencer overrides the single-cycle word for multiple transfers
    reg_list_sequencer seq_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instruction_i (instruction_i),
        .class_i       (instr_class),
        .base_ctrl_i   (base_ctrl),
        .link_imm_i    (link_imm),
        .ctrl_o        (ctrl_o),
        .xfer_o        (xfer_o)
    );

endmodule
